//--- include/rc5_consts.svh
`ifndef RC5_CONSTS_SVH
`define RC5_CONSTS_SVH

// word width in bits
`define RC5_W 32

// number of rounds
`define RC5_R 12

// expanded key table size, two words per round plus whitening pair
`define RC5_T (2 * `RC5_R + 2)

// secret key words (16 bytes)
`define RC5_C 4

// magic constants from the RC5 spec
`define RC5_P32 32'hB7E1_5163
`define RC5_Q32 32'h9E37_79B9

`endif

//--- design/rc5_pkg.sv
`include "rc5_consts.svh"

package rc5_pkg;

	// one cipher word
	typedef logic [`RC5_W-1:0] rc5_word_t;

	// rotate amount, low bits of a word
	typedef logic [$clog2(`RC5_W)-1:0] rc5_rot_t;

	// a is the upper half of the block
	typedef struct packed {
		rc5_word_t a;
		rc5_word_t b;
	} rc5_block_t;

	// secret key, word 0 in the low bits
	typedef rc5_word_t [`RC5_C-1:0] rc5_key_t;

	// expanded table S[0..25], S[0] in the low bits
	typedef rc5_word_t [`RC5_T-1:0] rc5_ktab_t;

	typedef enum logic [1:0] {
		KS_IDLE,
		KS_MIX,
		KS_DONE
	} ks_state_t;

endpackage

//--- design/rc5_key_sched.sv
`include "rc5_consts.svh"

module rc5_key_sched (
	input  logic               i_clk,
	input  logic               i_rst,
	input  rc5_pkg::rc5_key_t  i_key,
	input  logic               i_key_load,
	output rc5_pkg::rc5_ktab_t o_ktab,
	output logic               o_ready
);

	import rc5_pkg::*;

	ks_state_t  r_state;
	logic [6:0] r_step;
	logic [4:0] r_i;
	logic [1:0] r_j;
	logic       r_ready;

	// S table, L array and the running A/B words
	rc5_ktab_t  r_s;
	rc5_key_t   r_l;
	rc5_word_t  r_a;
	rc5_word_t  r_b;

	rc5_word_t  s_a_sum;
	rc5_word_t  s_a_new;
	rc5_word_t  s_b_sum;
	rc5_word_t  s_b_new;
	rc5_rot_t   s_b_rot;
	logic [2*`RC5_W-1:0] s_b_wide;

	// A = (S[i] + A + B) <<< 3
	assign s_a_sum = r_s[r_i] + r_a + r_b;
	assign s_a_new = {s_a_sum[`RC5_W-4:0], s_a_sum[`RC5_W-1:`RC5_W-3]};

	// B = (L[j] + A + B) <<< (A + B)
	assign s_b_rot  = rc5_rot_t'(s_a_new + r_b);
	assign s_b_sum  = r_l[r_j] + s_a_new + r_b;
	assign s_b_wide = {s_b_sum, s_b_sum} << s_b_rot;
	assign s_b_new  = s_b_wide[2*`RC5_W-1:`RC5_W];

	// sequencing; a load restarts from any state
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_state <= KS_IDLE;
			r_step  <= '0;
			r_i     <= '0;
			r_j     <= '0;
			r_ready <= 1'b0;
		end else if (i_key_load) begin
			r_state <= KS_MIX;
			r_step  <= '0;
			r_i     <= '0;
			r_j     <= '0;
			r_ready <= 1'b0;
		end else begin
			case (r_state)
				KS_MIX: begin
					r_step <= r_step + 7'd1;
					r_j    <= r_j + 2'd1;
					if (r_i == 5'(`RC5_T - 1)) begin
						r_i <= '0;
					end else begin
						r_i <= r_i + 5'd1;
					end
					// 3 * max(T, C) passes over the arrays
					if (r_step == 7'(3 * `RC5_T - 1)) begin
						r_state <= KS_DONE;
					end
				end
				KS_DONE: begin
					r_ready <= 1'b1;
				end
				default: begin
					r_ready <= 1'b0;
				end
			endcase
		end
	end

	// table and mixing words
	always_ff @(posedge i_clk) begin
		if (i_key_load) begin
			// S[k] = P + k*Q
			for (int k = 0; k < `RC5_T; k++) begin
				r_s[k] <= rc5_word_t'(`RC5_P32 + k * `RC5_Q32);
			end
			r_l <= i_key;
			r_a <= '0;
			r_b <= '0;
		end else if (r_state == KS_MIX) begin
			r_s[r_i] <= s_a_new;
			r_l[r_j] <= s_b_new;
			r_a      <= s_a_new;
			r_b      <= s_b_new;
		end
	end

	assign o_ktab  = r_s;
	assign o_ready = r_ready;

endmodule

//--- design/rc5_dpc.sv
`include "rc5_consts.svh"

module rc5_dpc (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_flag,
	input  rc5_pkg::rc5_ktab_t  i_ktab,
	input  logic                i_key_valid,
	input  rc5_pkg::rc5_block_t i_din,
	input  logic                i_din_en,
	output rc5_pkg::rc5_block_t o_dout,
	output logic                o_dout_en
);

	import rc5_pkg::*;

	logic [$clog2(`RC5_R)-1:0] r_count;

	// round keys 2..25 minus the pair used in the start cycle
	rc5_word_t [`RC5_T-5:0] r_keys;

	rc5_block_t r_blk;

	logic       s_start;
	rc5_word_t  s_ka;
	rc5_word_t  s_kb;
	rc5_word_t  s_in_a;
	rc5_word_t  s_in_b;
	rc5_block_t s_pre;
	rc5_block_t s_cur;
	rc5_block_t s_nxt;
	rc5_rot_t   s_rot0_amt;
	rc5_rot_t   s_rot1_amt;
	rc5_word_t  s_rot0_in;
	rc5_word_t  s_rot1_in;
	rc5_word_t  s_rot0;
	rc5_word_t  s_rot1;
	rc5_word_t  s_first;
	rc5_word_t  s_second;

	function automatic rc5_word_t swap_bytes(input rc5_word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// rotate left; right rotates use the negated amount
	function automatic rc5_word_t rol(input rc5_word_t w, input rc5_rot_t n);
		logic [2*`RC5_W-1:0] t;
		t = {w, w} << n;
		return t[2*`RC5_W-1:`RC5_W];
	endfunction

	assign s_start = i_din_en & i_key_valid;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_count <= '0;
		end else if (s_start) begin
			r_count <= 4'd1;
		end else if (r_count == 4'(`RC5_R - 1)) begin
			r_count <= '0;
		end else if (r_count != '0) begin
			r_count <= r_count + 4'd1;
		end
	end

	// encrypt walks up the table, decrypt walks down
	always_ff @(posedge i_clk) begin
		if (s_start) begin
			if (i_flag) begin
				r_keys <= i_ktab[`RC5_T-1:4];
			end else begin
				r_keys <= i_ktab[`RC5_T-3:2];
			end
		end else if (r_count != '0) begin
			if (i_flag) begin
				r_keys <= {{2{rc5_word_t'(0)}}, r_keys[`RC5_T-5:2]};
			end else begin
				r_keys <= {r_keys[`RC5_T-7:0], {2{rc5_word_t'(0)}}};
			end
		end
	end

	// key pair of the current round
	always_comb begin
		if (i_flag) begin
			s_ka = s_start ? i_ktab[2] : r_keys[0];
			s_kb = s_start ? i_ktab[3] : r_keys[1];
		end else begin
			s_ka = s_start ? i_ktab[`RC5_T-2] : r_keys[`RC5_T-6];
			s_kb = s_start ? i_ktab[`RC5_T-1] : r_keys[`RC5_T-5];
		end
	end

	assign s_in_a = swap_bytes(i_din.a);
	assign s_in_b = swap_bytes(i_din.b);

	// pre-whitening only on encrypt
	assign s_pre.a = i_flag ? s_in_a + i_ktab[0] : s_in_a;
	assign s_pre.b = i_flag ? s_in_b + i_ktab[1] : s_in_b;

	assign s_cur = s_start ? s_pre : r_blk;

	// enc: A = ((A ^ B) <<< B) + S[2i],  B = ((B ^ A) <<< A) + S[2i+1]
	// dec: B = ((B - S[2i+1]) >>> A) ^ A,  A = ((A - S[2i]) >>> B) ^ B
	assign s_rot0_amt = i_flag ? s_cur.b[4:0] : -s_cur.a[4:0];
	assign s_rot0_in  = i_flag ? s_cur.a ^ s_cur.b : s_cur.b - s_kb;
	assign s_rot0     = rol(s_rot0_in, s_rot0_amt);

	// new A on encrypt, new B on decrypt
	assign s_first = i_flag ? s_rot0 + s_ka : s_rot0 ^ s_cur.a;

	assign s_rot1_amt = i_flag ? s_first[4:0] : -s_first[4:0];
	assign s_rot1_in  = i_flag ? s_cur.b ^ s_first : s_cur.a - s_ka;
	assign s_rot1     = rol(s_rot1_in, s_rot1_amt);

	assign s_second = i_flag ? s_rot1 + s_kb : s_rot1 ^ s_first;

	assign s_nxt.a = i_flag ? s_first : s_second;
	assign s_nxt.b = i_flag ? s_second : s_first;

	always_ff @(posedge i_clk) begin
		r_blk <= s_nxt;
	end

	// post-whitening on decrypt, then back to byte order
	assign o_dout.a = i_flag ? swap_bytes(s_nxt.a) : swap_bytes(s_nxt.a - i_ktab[0]);
	assign o_dout.b = i_flag ? swap_bytes(s_nxt.b) : swap_bytes(s_nxt.b - i_ktab[1]);

	assign o_dout_en = (r_count == 4'(`RC5_R - 1));

endmodule

//--- design/rc5_core.sv
module rc5_core (
	input  logic                i_clk,
	input  logic                i_rst,
	input  rc5_pkg::rc5_key_t   i_key,
	input  logic                i_key_load,
	input  logic                i_flag,
	input  rc5_pkg::rc5_block_t i_din,
	input  logic                i_din_en,
	output logic                o_key_ready,
	output rc5_pkg::rc5_block_t o_dout,
	output logic                o_dout_en
);

	import rc5_pkg::*;

	// expanded table, stable while o_key_ready is high
	rc5_ktab_t s_ktab;

	rc5_key_sched u_key_sched (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_key      (i_key),
		.i_key_load (i_key_load),
		.o_ktab     (s_ktab),
		.o_ready    (o_key_ready)
	);

	// ready also qualifies block starts
	rc5_dpc u_dpc (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_flag      (i_flag),
		.i_ktab      (s_ktab),
		.i_key_valid (o_key_ready),
		.i_din       (i_din),
		.i_din_en    (i_din_en),
		.o_dout      (o_dout),
		.o_dout_en   (o_dout_en)
	);

endmodule

//--- include/rc5_ref_model.svh
`ifndef RC5_REF_MODEL_SVH
`define RC5_REF_MODEL_SVH

`include "rc5_consts.svh"

// expanded table, S[k] at bits 32k and up
typedef logic [`RC5_T*`RC5_W-1:0] model_tab_t;

function automatic logic [31:0] model_rotl(input logic [31:0] x, input int unsigned n);
	int unsigned s;
	s = n % 32;
	if (s == 0) begin
		return x;
	end
	return (x << s) | (x >> (32 - s));
endfunction

function automatic logic [31:0] model_rotr(input logic [31:0] x, input int unsigned n);
	int unsigned s;
	s = n % 32;
	if (s == 0) begin
		return x;
	end
	return (x >> s) | (x << (32 - s));
endfunction

// bus words carry the bytes in reverse order
function automatic logic [31:0] byte_rev(input logic [31:0] w);
	return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic model_tab_t expand_key(input logic [127:0] key);
	logic [31:0] s [`RC5_T];
	logic [31:0] l [`RC5_C];
	logic [31:0] a;
	logic [31:0] b;
	int          i;
	int          j;
	model_tab_t  tab;
	for (int k = 0; k < `RC5_C; k++) begin
		l[k] = key[32*k +: 32];
	end
	s[0] = `RC5_P32;
	for (int k = 1; k < `RC5_T; k++) begin
		s[k] = s[k-1] + `RC5_Q32;
	end
	a = '0;
	b = '0;
	i = 0;
	j = 0;
	// three passes over the larger array
	for (int k = 0; k < 3 * `RC5_T; k++) begin
		a = model_rotl(s[i] + a + b, 3);
		s[i] = a;
		b = model_rotl(l[j] + a + b, a + b);
		l[j] = b;
		i = (i + 1) % `RC5_T;
		j = (j + 1) % `RC5_C;
	end
	for (int k = 0; k < `RC5_T; k++) begin
		tab[32*k +: 32] = s[k];
	end
	return tab;
endfunction

function automatic logic [63:0] model_encrypt(input model_tab_t tab, input logic [63:0] blk);
	logic [31:0] a;
	logic [31:0] b;
	a = byte_rev(blk[63:32]) + tab[0 +: 32];
	b = byte_rev(blk[31:0]) + tab[32 +: 32];
	for (int r = 1; r <= `RC5_R; r++) begin
		a = model_rotl(a ^ b, b) + tab[64*r +: 32];
		b = model_rotl(b ^ a, a) + tab[64*r+32 +: 32];
	end
	return {byte_rev(a), byte_rev(b)};
endfunction

function automatic logic [63:0] model_decrypt(input model_tab_t tab, input logic [63:0] blk);
	logic [31:0] a;
	logic [31:0] b;
	a = byte_rev(blk[63:32]);
	b = byte_rev(blk[31:0]);
	for (int r = `RC5_R; r >= 1; r--) begin
		b = model_rotr(b - tab[64*r+32 +: 32], a) ^ a;
		a = model_rotr(a - tab[64*r +: 32], b) ^ b;
	end
	b = b - tab[32 +: 32];
	a = a - tab[0 +: 32];
	return {byte_rev(a), byte_rev(b)};
endfunction

`endif

//--- tests/rc5_core_tb.sv
module rc5_core_tb;

	import rc5_pkg::*;

	`include "rc5_ref_model.svh"

	localparam int          CLK_PERIOD  = 40;
	localparam int          N_KEYS      = 8;
	localparam int          N_BLOCKS    = 50;
	localparam int          LATENCY     = 11;
	localparam int          READY_DELAY = 79;
	localparam logic [63:0] KAT_ZERO_CT = 64'h21A5_DBEE_154B_8F6D;

	// loads and blocks over all tests
	localparam int N_LOADS         = 3 + 2 * N_KEYS;
	localparam int N_RUNS          = 3 + 4 * N_KEYS * N_BLOCKS;
	localparam int WATCHDOG_CYCLES = 100 * N_LOADS + 15 * N_RUNS + 500;

	logic       i_clk;
	logic       i_rst;
	rc5_key_t   i_key;
	logic       i_key_load;
	logic       i_flag;
	rc5_block_t i_din;
	logic       i_din_en;
	logic       o_key_ready;
	rc5_block_t o_dout;
	logic       o_dout_en;

	logic [31:0] lcg_state;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_ok;

	rc5_core DUT (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_key       (i_key),
		.i_key_load  (i_key_load),
		.i_flag      (i_flag),
		.i_din       (i_din),
		.i_din_en    (i_din_en),
		.o_key_ready (o_key_ready),
		.o_dout      (o_dout),
		.o_dout_en   (o_dout_en)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [63:0] random_block();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_random();
		lo = next_random();
		return {hi, lo};
	endfunction

	function automatic logic [127:0] random_key();
		logic [63:0] hi;
		logic [63:0] lo;
		hi = random_block();
		lo = random_block();
		return {hi, lo};
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// returns on the edge where the DUT samples the load
	task automatic load_key(input logic [127:0] key);
		@(posedge i_clk);
		i_key      <= key;
		i_key_load <= 1'b1;
		@(posedge i_clk);
		i_key_load <= 1'b0;
	endtask

	task automatic wait_ready(output int cycles);
		cycles = 0;
		do begin
			@(posedge i_clk);
			cycles++;
			@(negedge i_clk);
		end while (!o_key_ready && cycles < 200);
		assert (o_key_ready) else begin
			$display("key schedule did not raise o_key_ready within %0d cycles", cycles);
			test_errors++;
		end
	endtask

	task automatic start_block(input logic flag, input logic [63:0] blk);
		@(posedge i_clk);
		i_flag   <= flag;
		i_din    <= blk;
		i_din_en <= 1'b1;
		@(posedge i_clk);
		i_din_en <= 1'b0;
	endtask

	// lat counts the cycles after the start edge and is 0 without a strobe
	task automatic wait_output(output logic [63:0] res, output int lat);
		res = '0;
		lat = 0;
		do begin
			@(negedge i_clk);
			lat++;
		end while (!o_dout_en && lat < 40);
		assert (o_dout_en) else begin
			$display("no output strobe within %0d cycles of the input strobe", lat);
			test_errors++;
			lat = 0;
		end
		if (lat > 0) begin
			res = o_dout;
		end
	endtask

	task automatic run_and_check(input logic flag, input logic [63:0] blk,
			input logic [63:0] exp, input string what, output logic [63:0] got);
		int lat;
		start_block(flag, blk);
		wait_output(got, lat);
		if (lat > 0) begin
			assert (lat == LATENCY) else begin
				$display("Mismatch at %0t: %s strobe after %0d cycles, expected %0d",
					$time, what, lat, LATENCY);
				test_errors++;
			end
			check_value(got, exp, what);
		end
	endtask

	initial begin
		int           cycles;
		int           pulses;
		int           first_lat;
		logic [127:0] key;
		logic [63:0]  p;
		logic [63:0]  p2;
		logic [63:0]  c;
		logic [63:0]  got;
		logic [63:0]  back;
		model_tab_t   tab;

		i_clk        = 1'b0;
		i_rst        = 1'b1;
		i_key        = '0;
		i_key_load   = 1'b0;
		i_flag       = 1'b1;
		i_din        = '0;
		i_din_en     = 1'b0;
		lcg_state    = 32'h2682_5d80;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_ok     = 0;

		repeat (4) @(posedge i_clk);
		i_rst <= 1'b0;
		@(negedge i_clk);

		// reset state and key schedule latency
		assert (!o_key_ready && !o_dout_en) else begin
			$display("Mismatch at %0t: ready=%b dout_en=%b after reset, expected both low",
				$time, o_key_ready, o_dout_en);
			test_errors++;
		end
		load_key(random_key());
		wait_ready(cycles);
		assert (cycles == READY_DELAY) else begin
			$display("Mismatch at %0t: o_key_ready rose %0d cycles after load, expected %0d",
				$time, cycles, READY_DELAY);
			test_errors++;
		end
		finish_test("reset_and_ready");

		// all-zero key and plaintext
		load_key('0);
		wait_ready(cycles);
		tab = expand_key('0);
		run_and_check(1'b1, '0, model_encrypt(tab, '0), "zero key vs model", got);
		check_value(got, KAT_ZERO_CT, "zero key vs published vector");
		finish_test("known_answer");

		for (int k = 0; k < N_KEYS; k++) begin
			key = random_key();
			tab = expand_key(key);
			load_key(key);
			wait_ready(cycles);
			for (int n = 0; n < N_BLOCKS; n++) begin
				p = random_block();
				run_and_check(1'b1, p, model_encrypt(tab, p),
					$sformatf("encrypt key %0d block %0d", k, n), got);
			end
		end
		finish_test("random_encrypt");

		for (int k = 0; k < N_KEYS; k++) begin
			key = random_key();
			tab = expand_key(key);
			load_key(key);
			wait_ready(cycles);
			for (int n = 0; n < N_BLOCKS; n++) begin
				p = random_block();
				run_and_check(1'b1, p, model_encrypt(tab, p),
					$sformatf("round trip encrypt key %0d block %0d", k, n), c);
				run_and_check(1'b0, c, p,
					$sformatf("round trip decrypt key %0d block %0d", k, n), back);
				c = random_block();
				run_and_check(1'b0, c, model_decrypt(tab, c),
					$sformatf("decrypt key %0d block %0d", k, n), got);
			end
		end
		finish_test("random_decrypt");

		// a block offered before the key is ready must be dropped
		key = random_key();
		tab = expand_key(key);
		load_key(key);
		start_block(1'b1, random_block());
		pulses = 0;
		repeat (20) begin
			@(negedge i_clk);
			if (o_dout_en) begin
				pulses++;
			end
		end
		assert (pulses == 0) else begin
			$display("Mismatch at %0t: %0d output strobes while the key was not ready",
				$time, pulses);
			test_errors++;
		end
		wait_ready(cycles);

		// restart in the middle of a block
		p  = random_block();
		p2 = random_block();
		start_block(1'b1, p);
		repeat (4) @(posedge i_clk);
		start_block(1'b1, p2);
		pulses    = 0;
		first_lat = 0;
		got       = '0;
		for (int n = 1; n <= 30; n++) begin
			@(negedge i_clk);
			if (o_dout_en) begin
				pulses++;
				if (pulses == 1) begin
					first_lat = n;
					got       = o_dout;
				end
			end
		end
		assert (pulses == 1 && first_lat == LATENCY) else begin
			$display("Mismatch at %0t: %0d strobes after restart, first at %0d, expected 1 at %0d",
				$time, pulses, first_lat, LATENCY);
			test_errors++;
		end
		check_value(got, model_encrypt(tab, p2), "restarted block");
		finish_test("control_rules");

		$display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
			tests_run, tests_ok, tests_run - tests_ok, total_errors);
		if (total_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- rc5_core.f
+incdir+include
design/rc5_pkg.sv
design/rc5_key_sched.sv
design/rc5_dpc.sv
design/rc5_core.sv
tests/rc5_core_tb.sv

//--- run.sh
#!/bin/sh
# build the RC5 core testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f rc5_core.f --top-module rc5_core_tb -o rc5_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rc5_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
